// ==== logic/fpFormatPkg.sv ====
// Binary32 layout only; signalling and quiet NaNs are not told apart anywhere in the design
package fpFormatPkg;

    // Field order matches the IEEE 754 binary32 bit layout
    typedef struct packed {
        logic        sign;
        logic [7:0]  exponent;
        logic [22:0] fraction;
    } fpWordT;

    // Operand class, decoded once in the first stage
    typedef struct packed {
        logic isNaN;
        logic isInf;
        logic isZero;
        logic isSub;
    } fpClassT;

    typedef struct packed {
        logic invalid;
        logic overflow;
        logic inexact;
    } fpFlagsT;

    localparam int expBias = 127;

    // All-ones exponent marks infinity and NaN
    localparam logic [7:0] expMax = 8'd255;

endpackage

// ==== logic/fpPipePkg.sv ====
// Stage records assume the binary32 layout of fpFormatPkg; significands carry 8 guard bits
package fpPipePkg;

    typedef enum logic {
        opAdd,
        opSub
    } fpOpT;

    typedef enum logic [1:0] {
        stIdle,
        stBusy,
        stDone
    } reqStateT;

    // B's sign already includes the opcode; subnormal and zero exponents read as 1
    typedef struct packed {
        logic                 valid;
        logic                 signA;
        logic                 signB;
        logic [7:0]           expA;
        logic [7:0]           expB;
        logic [22:0]          fracA;
        logic [22:0]          fracB;
        fpFormatPkg::fpClassT classA;
        fpFormatPkg::fpClassT classB;
    } unpackOutT;

    // Significands are {hidden, fraction, 8 guard bits}
    typedef struct packed {
        logic                 valid;
        logic                 signA;
        logic                 signB;
        logic [7:0]           expOut;
        logic [31:0]          sigA;
        logic [31:0]          sigB;
        logic                 sticky;
        logic                 shiftOverflow;
        logic                 bypass;
        fpFormatPkg::fpClassT classA;
        fpFormatPkg::fpClassT classB;
    } alignOutT;

    typedef struct packed {
        logic                 valid;
        logic                 sign;
        logic [7:0]           exponent;
        logic [32:0]          mag;
        logic                 sticky;
        logic                 bypass;
        fpFormatPkg::fpClassT classA;
        fpFormatPkg::fpClassT classB;
    } sumOutT;

endpackage

// ==== logic/fpUnpack.sv ====
// Stage 1; takes a single-cycle launch pulse and gives zero and subnormal operands exponent 1
module fpUnpack (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  launch,
    input  fpFormatPkg::fpWordT   capA,
    input  fpFormatPkg::fpWordT   capB,
    input  fpPipePkg::fpOpT       capOp,
    output fpPipePkg::unpackOutT  stage
);

    fpPipePkg::unpackOutT next;

    function automatic fpFormatPkg::fpClassT classify(input fpFormatPkg::fpWordT w);
        fpFormatPkg::fpClassT c;
        logic expOnes;
        logic expZero;
        logic fracZero;
        expOnes  = (w.exponent == fpFormatPkg::expMax);
        expZero  = (w.exponent == 8'd0);
        fracZero = (w.fraction == 23'd0);
        c.isNaN  = expOnes & ~fracZero;
        c.isInf  = expOnes & fracZero;
        c.isZero = expZero & fracZero;
        c.isSub  = expZero & ~fracZero;
        return c;
    endfunction

    // Denormals share the scale of exponent 1, only the hidden bit differs
    function automatic logic [7:0] alignExp(input fpFormatPkg::fpWordT w);
        return (w.exponent == 8'd0) ? 8'd1 : w.exponent;
    endfunction

    always_comb
    begin
        next.valid  = launch;
        next.signA  = capA.sign;
        next.signB  = capB.sign ^ (capOp == fpPipePkg::opSub);
        next.expA   = alignExp(capA);
        next.expB   = alignExp(capB);
        next.fracA  = capA.fraction;
        next.fracB  = capB.fraction;
        next.classA = classify(capA);
        next.classB = classify(capB);
    end

    always_ff @(posedge clk)
    begin
        stage <= next;
        if (rst)
            stage.valid <= 1'b0;
    end

endmodule

// ==== logic/fpAlign.sv ====
// Stage 2; shifts beyond 32 places leave only the sticky bit of the smaller operand
module fpAlign (
    input  logic                 clk,
    input  logic                 rst,
    input  fpPipePkg::unpackOutT in,
    output fpPipePkg::alignOutT  stage
);

    fpPipePkg::alignOutT next;
    logic        aBigger;
    logic        bBigger;
    logic        hiddenA;
    logic        hiddenB;
    logic [31:0] sigA;
    logic [31:0] sigB;
    logic [31:0] smallSig;
    logic [7:0]  expDiff;
    logic [5:0]  shiftAmt;
    logic        shiftOverflow;
    logic [63:0] wide;

    assign aBigger = (in.expA > in.expB);
    assign bBigger = (in.expB > in.expA);

    // Hidden bit only for normal operands
    assign hiddenA = ~(in.classA.isSub | in.classA.isZero);
    assign hiddenB = ~(in.classB.isSub | in.classB.isZero);
    assign sigA    = {hiddenA, in.fracA, 8'b0};
    assign sigB    = {hiddenB, in.fracB, 8'b0};

    always_comb
    begin
        if (aBigger)
        begin
            next.expOut = in.expA;
            expDiff     = in.expA - in.expB;
            smallSig    = sigB;
        end
        else if (bBigger)
        begin
            next.expOut = in.expB;
            expDiff     = in.expB - in.expA;
            smallSig    = sigA;
        end
        else
        begin
            next.expOut = in.expA;
            expDiff     = 8'd0;
            smallSig    = sigB;
        end

        shiftOverflow = (expDiff >= 8'd32);
        shiftAmt      = shiftOverflow ? 6'd32 : expDiff[5:0];
        // Lower half collects every bit pushed past the guard field
        wide          = {smallSig, 32'b0} >> shiftAmt;

        next.valid         = in.valid;
        next.signA         = in.signA;
        next.signB         = in.signB;
        next.sigA          = bBigger ? wide[63:32] : sigA;
        next.sigB          = aBigger ? wide[63:32] : sigB;
        next.sticky        = |wide[31:0];
        next.shiftOverflow = shiftOverflow;
        next.bypass        = in.classA.isNaN | in.classB.isNaN | in.classA.isInf |
                             in.classB.isInf | in.classA.isZero | in.classB.isZero;
        next.classA        = in.classA;
        next.classB        = in.classB;
    end

    always_ff @(posedge clk)
    begin
        stage <= next;
        if (rst)
            stage.valid <= 1'b0;
    end

endmodule

// ==== logic/fpMantAdd.sv ====
// Stage 3; opposite infinities leave this stage marked as a NaN operand
module fpMantAdd (
    input  logic                clk,
    input  logic                rst,
    input  fpPipePkg::alignOutT in,
    output fpPipePkg::sumOutT   stage
);

    fpPipePkg::sumOutT next;
    logic        effSub;
    logic        aGeB;
    logic [31:0] bigSig;
    logic [31:0] smallSig;
    logic [33:0] res;
    logic        infSign;

    assign effSub   = in.signA ^ in.signB;
    assign aGeB     = (in.sigA >= in.sigB);
    assign bigSig   = aGeB ? in.sigA : in.sigB;
    assign smallSig = aGeB ? in.sigB : in.sigA;
    assign infSign  = in.classA.isInf ? in.signA : in.signB;

    always_comb
    begin
        // The sticky bit rides below the smaller operand so a borrow reaches the guard bits
        if (in.shiftOverflow)
            res = {1'b0, bigSig, in.sticky};
        else if (effSub)
            res = {1'b0, bigSig, 1'b0} - {1'b0, smallSig, in.sticky};
        else
            res = {1'b0, bigSig, 1'b0} + {1'b0, smallSig, in.sticky};

        next.valid    = in.valid;
        next.exponent = in.expOut;
        next.mag      = res[33:1];
        next.sticky   = res[0];
        next.bypass   = in.bypass;
        next.classA   = in.classA;
        next.classB   = in.classB;

        if (in.bypass && (in.classA.isInf || in.classB.isInf))
            next.sign = infSign;
        else if (res == 34'd0)
            next.sign = in.signA & ~effSub;
        else
            next.sign = (effSub && !aGeB) ? in.signB : in.signA;

        if (in.classA.isInf && in.classB.isInf && effSub)
            next.classA.isNaN = 1'b1;
    end

    always_ff @(posedge clk)
    begin
        stage <= next;
        if (rst)
            stage.valid <= 1'b0;
    end

endmodule

// ==== logic/fpNormRound.sv ====
// Stage 4; nearest even only; normalizing stops at exponent 1, so tiny sums stay subnormal
module fpNormRound (
    input  logic                clk,
    input  logic                rst,
    input  fpPipePkg::sumOutT   in,
    output logic                doneValid,
    output fpFormatPkg::fpWordT doneResult,
    output fpFormatPkg::fpFlagsT doneFlags
);

    fpFormatPkg::fpWordT  resultN;
    fpFormatPkg::fpFlagsT flagsN;
    logic [5:0]  lz;
    logic [7:0]  shiftAmt;
    logic [31:0] norm;
    logic [9:0]  expAdj;
    logic [9:0]  expRnd;
    logic        stickyAll;
    logic        guardBit;
    logic        restBits;
    logic        roundUp;
    logic [24:0] rounded;
    logic [23:0] sigOut;
    logic        nanCase;
    logic        infCase;

    assign nanCase = in.bypass & (in.classA.isNaN | in.classB.isNaN);
    assign infCase = in.bypass & (in.classA.isInf | in.classB.isInf);

    always_comb
    begin
        lz = 6'd32;
        for (int i = 0; i < 32; i++)
            if (in.mag[i])
                lz = 6'(31 - i);

        shiftAmt = 8'd0;
        if (in.mag[32])
        begin
            norm      = in.mag[32:1];
            stickyAll = in.sticky | in.mag[0];
            expAdj    = {2'b0, in.exponent} + 10'd1;
        end
        else
        begin
            shiftAmt  = ({2'b0, lz} > in.exponent - 8'd1) ? in.exponent - 8'd1 : {2'b0, lz};
            norm      = in.mag[31:0] << shiftAmt;
            stickyAll = in.sticky;
            expAdj    = {2'b0, in.exponent} - {2'b0, shiftAmt};
        end

        guardBit = norm[7];
        restBits = (|norm[6:0]) | stickyAll;
        roundUp  = guardBit & (restBits | norm[8]);
        rounded  = {1'b0, norm[31:8]} + {24'd0, roundUp};

        if (rounded[24])
        begin
            sigOut = rounded[24:1];
            expRnd = expAdj + 10'd1;
        end
        else
        begin
            sigOut = rounded[23:0];
            expRnd = expAdj;
        end

        flagsN = '0;
        if (nanCase)
        begin
            resultN.sign     = 1'b0;
            resultN.exponent = fpFormatPkg::expMax;
            resultN.fraction = 23'h400000;
            flagsN.invalid   = 1'b1;
        end
        else if (infCase)
        begin
            resultN.sign     = in.sign;
            resultN.exponent = fpFormatPkg::expMax;
            resultN.fraction = 23'd0;
        end
        else if (expRnd >= {2'b0, fpFormatPkg::expMax})
        begin
            resultN.sign     = in.sign;
            resultN.exponent = fpFormatPkg::expMax;
            resultN.fraction = 23'd0;
            flagsN.overflow  = 1'b1;
            flagsN.inexact   = 1'b1;
        end
        else
        begin
            // No hidden bit after rounding means a subnormal, packed with exponent 0
            resultN.sign     = in.sign;
            resultN.exponent = sigOut[23] ? expRnd[7:0] : 8'd0;
            resultN.fraction = sigOut[22:0];
            flagsN.inexact   = guardBit | restBits;
        end
    end

    always_ff @(posedge clk)
    begin
        doneResult <= resultN;
        doneFlags  <= flagsN;
        if (rst)
            doneValid <= 1'b0;
        else
            doneValid <= in.valid;
    end

endmodule

// ==== logic/fpReqAck.sv ====
// Four-phase slave; one operation at a time, and req must stay low until ack has fallen
module fpReqAck (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 req,
    input  fpFormatPkg::fpWordT  opA,
    input  fpFormatPkg::fpWordT  opB,
    input  fpPipePkg::fpOpT      op,
    input  logic                 doneValid,
    input  fpFormatPkg::fpWordT  doneResult,
    input  fpFormatPkg::fpFlagsT doneFlags,
    output logic                 ack,
    output logic                 launch,
    output fpFormatPkg::fpWordT  capA,
    output fpFormatPkg::fpWordT  capB,
    output fpPipePkg::fpOpT      capOp,
    output fpFormatPkg::fpWordT  result,
    output fpFormatPkg::fpFlagsT flags
);

    fpPipePkg::reqStateT state;

    assign ack = (state == fpPipePkg::stDone);

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state  <= fpPipePkg::stIdle;
            launch <= 1'b0;
        end
        else
        begin
            launch <= 1'b0;
            case (state)
                fpPipePkg::stIdle:
                    if (req)
                    begin
                        launch <= 1'b1;
                        state  <= fpPipePkg::stBusy;
                    end
                fpPipePkg::stBusy:
                    if (doneValid)
                        state <= fpPipePkg::stDone;
                fpPipePkg::stDone:
                    if (!req)
                        state <= fpPipePkg::stIdle;
                default:
                    state <= fpPipePkg::stIdle;
            endcase
        end
    end

    // Operands and result are held in their own registers for the whole handshake
    always_ff @(posedge clk)
    begin
        if (state == fpPipePkg::stIdle && req)
        begin
            capA  <= opA;
            capB  <= opB;
            capOp <= op;
        end
        if (state == fpPipePkg::stBusy && doneValid)
        begin
            result <= doneResult;
            flags  <= doneFlags;
        end
    end

endmodule

// ==== logic/fpAddTop.sv ====
// Binary32 add and subtract behind a four-phase handshake; ack rises five clocks after req is sampled
module fpAddTop (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 req,
    input  fpFormatPkg::fpWordT  opA,
    input  fpFormatPkg::fpWordT  opB,
    input  fpPipePkg::fpOpT      op,
    output logic                 ack,
    output fpFormatPkg::fpWordT  result,
    output fpFormatPkg::fpFlagsT flags
);

    logic                 launch;
    fpFormatPkg::fpWordT  capA;
    fpFormatPkg::fpWordT  capB;
    fpPipePkg::fpOpT      capOp;
    fpPipePkg::unpackOutT unpackStage;
    fpPipePkg::alignOutT  alignStage;
    fpPipePkg::sumOutT    sumStage;
    logic                 doneValid;
    fpFormatPkg::fpWordT  doneResult;
    fpFormatPkg::fpFlagsT doneFlags;

    fpReqAck fpReqAck_inst (
        .clk(clk), .rst(rst), .req(req),
        .opA(opA), .opB(opB), .op(op),
        .doneValid(doneValid), .doneResult(doneResult), .doneFlags(doneFlags),
        .ack(ack), .launch(launch),
        .capA(capA), .capB(capB), .capOp(capOp),
        .result(result), .flags(flags)
    );

    fpUnpack fpUnpack_inst (
        .clk(clk), .rst(rst), .launch(launch),
        .capA(capA), .capB(capB), .capOp(capOp),
        .stage(unpackStage)
    );

    fpAlign fpAlign_inst (.clk(clk), .rst(rst), .in(unpackStage), .stage(alignStage));

    fpMantAdd fpMantAdd_inst (.clk(clk), .rst(rst), .in(alignStage), .stage(sumStage));

    fpNormRound fpNormRound_inst (
        .clk(clk), .rst(rst), .in(sumStage),
        .doneValid(doneValid), .doneResult(doneResult), .doneFlags(doneFlags)
    );

endmodule

// ==== tb/fpAdd_assertions.sv ====
// Assumes a free-running clock through reset; checks only the four-phase handshake at the top level
module fpAdd_assertions (
    input logic                clk,
    input logic                rst,
    input logic                req,
    input logic                ack,
    input fpFormatPkg::fpWordT result
);

    int failCount = 0;

    // Sampled one edge back, since the requester may drop req as soon as it sees ack
    ackNeedsReq: assert property (@(posedge clk) disable iff (rst) $rose(ack) |-> $past(req))
    else
    begin
        $error("ack rose while req was low");
        failCount++;
    end

    ackHeldForReq: assert property (@(posedge clk) disable iff (rst) (ack && req) |=> ack)
    else
    begin
        $error("ack fell while req was still high");
        failCount++;
    end

    resultHeld: assert property (@(posedge clk) disable iff (rst)
        ($past(ack) && ack) |-> $stable(result))
    else
    begin
        $error("result changed while ack was high");
        failCount++;
    end

    ackLowAfterReset: assert property (@(posedge clk) rst |=> !ack)
    else
    begin
        $error("ack was high in the cycle after reset");
        failCount++;
    end

endmodule

bind fpAddTop fpAdd_assertions handshakeChecks (
    .clk(clk),
    .rst(rst),
    .req(req),
    .ack(ack),
    .result(result)
);

// ==== tb/fpAddTb.sv ====
// Directed tests with nearest-even expectations; an error or a hung handshake stops the run
module fpAddTb;

    typedef fpFormatPkg::fpWordT  wordT;
    typedef fpFormatPkg::fpFlagsT flagsT;

    // About 25 operations of at most 60 cycles each, with margin
    localparam int timeoutCycles = 2000;

    logic  clk;
    logic  rst;
    logic  req;
    wordT  opA;
    wordT  opB;
    fpPipePkg::fpOpT op;
    logic  ack;
    wordT  result;
    flagsT flags;
    int    cycles = 0;

    fpAddTop fpAddTop_inst (
        .clk(clk), .rst(rst), .req(req),
        .opA(opA), .opB(opB), .op(op),
        .ack(ack), .result(result), .flags(flags)
    );

    initial
    begin
        clk = 1'b0;
        forever
            #4 clk = ~clk;
    end

    task automatic failRun(input string reason);
        $display("%s", reason);
        $display("Testbench failed");
        $fatal(1, "run stopped at the first error");
    endtask

    always @(posedge clk)
    begin
        cycles++;
        if (cycles >= timeoutCycles)
            failRun($sformatf("timeout: the run did not finish within %0d cycles", timeoutCycles));
        else if (fpAddTop_inst.handshakeChecks.failCount != 0)
            failRun("a handshake assertion failed");
    end

    task automatic checkBit(input string name, input logic expected, input logic actual);
        if (actual !== expected)
            failRun($sformatf("mismatch at %0t: %s expected %b got %b",
                $time, name, expected, actual));
    endtask

    task automatic checkWord(input string name, input wordT expected, input wordT actual);
        if (actual !== expected)
            failRun($sformatf("mismatch at %0t: %s expected %h got %h",
                $time, name, expected, actual));
    endtask

    task automatic checkFlags(input string name, input flagsT expected, input flagsT actual);
        if (actual !== expected)
            failRun($sformatf("mismatch at %0t: %s expected %b got %b",
                $time, name, expected, actual));
    endtask

    // One full four-phase cycle, sampling the result on the falling edge while ack is high
    task automatic transfer(input wordT a, input wordT b, input fpPipePkg::fpOpT code,
                            input int holdCycles, input int gapCycles,
                            output wordT res, output flagsT fl);
        @(negedge clk);
        opA = a;
        opB = b;
        op  = code;
        req = 1'b1;
        while (ack !== 1'b1)
            @(negedge clk);
        res = result;
        fl  = flags;
        repeat (holdCycles)
            @(negedge clk);
        req = 1'b0;
        while (ack !== 1'b0)
            @(negedge clk);
        repeat (gapCycles)
            @(negedge clk);
    endtask

    task automatic runCase(input string label, input wordT a, input wordT b,
                           input fpPipePkg::fpOpT code, input wordT expWord,
                           input flagsT expFlags, input bit delayed);
        wordT  res;
        flagsT fl;
        int    hold;
        int    gap;
        hold = delayed ? $urandom_range(20, 0) : 0;
        gap  = delayed ? $urandom_range(15, 0) : 0;
        transfer(a, b, code, hold, gap, res, fl);
        checkWord({label, " result"}, expWord, res);
        checkFlags({label, " flags"}, expFlags, fl);
    endtask

    task automatic idleAfterReset();
        repeat (10)
        begin
            @(negedge clk);
            checkBit("ack", 1'b0, ack);
        end
    endtask

    task automatic exactSums(input bit delayed);
        runCase("1+1", 32'h3F800000, 32'h3F800000, fpPipePkg::opAdd, 32'h40000000, 3'b000,
            delayed);
        runCase("1.5+2.25", 32'h3FC00000, 32'h40100000, fpPipePkg::opAdd, 32'h40700000,
            3'b000, delayed);
    endtask

    // Flags are {invalid, overflow, inexact}
    task automatic roundToEven(input bit delayed);
        runCase("tie to even", 32'h3F800000, 32'h33800000, fpPipePkg::opAdd, 32'h3F800000,
            3'b001, delayed);
        runCase("above tie", 32'h3F800000, 32'h33800001, fpPipePkg::opAdd, 32'h3F800001,
            3'b001, delayed);
    endtask

    task automatic subtractions(input bit delayed);
        runCase("1.5-1", 32'h3FC00000, 32'h3F800000, fpPipePkg::opSub, 32'h3F000000,
            3'b000, delayed);
        runCase("x-x", 32'h40490FDB, 32'h40490FDB, fpPipePkg::opSub, 32'h00000000,
            3'b000, delayed);
        runCase("subnormal", 32'h00000001, 32'h00000001, fpPipePkg::opAdd, 32'h00000002,
            3'b000, delayed);
        runCase("cancel", 32'h3F800001, 32'h3F800000, fpPipePkg::opSub, 32'h34000000,
            3'b000, delayed);
    endtask

    task automatic specialOperands(input bit delayed);
        runCase("inf-inf", 32'h7F800000, 32'h7F800000, fpPipePkg::opSub, 32'h7FC00000,
            3'b100, delayed);
        runCase("nan in", 32'h7FC00000, 32'h3F800000, fpPipePkg::opAdd, 32'h7FC00000,
            3'b100, delayed);
        runCase("5-0", 32'h40A00000, 32'h80000000, fpPipePkg::opAdd, 32'h40A00000,
            3'b000, delayed);
        runCase("overflow", 32'h7F7FFFFF, 32'h7F7FFFFF, fpPipePkg::opAdd, 32'h7F800000,
            3'b011, delayed);
    endtask

    task automatic delayedHandshakes();
        exactSums(1'b1);
        roundToEven(1'b1);
        subtractions(1'b1);
        specialOperands(1'b1);
    endtask

    initial
    begin
        void'($urandom(32'habc3));
        rst = 1'b1;
        req = 1'b0;
        opA = '0;
        opB = '0;
        op  = fpPipePkg::opAdd;
        repeat (4)
            @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        idleAfterReset();
        exactSums(1'b0);
        roundToEven(1'b0);
        subtractions(1'b0);
        specialOperands(1'b0);
        delayedHandshakes();

        @(negedge clk);
        if (fpAddTop_inst.handshakeChecks.failCount != 0)
            failRun("a handshake assertion failed");
        else
        begin
            $display("Testbench passed");
            $finish;
        end
    end

endmodule

// ==== list.f ====
logic/fpFormatPkg.sv
logic/fpPipePkg.sv
logic/fpUnpack.sv
logic/fpAlign.sv
logic/fpMantAdd.sv
logic/fpNormRound.sv
logic/fpReqAck.sv
logic/fpAddTop.sv
tb/fpAdd_assertions.sv
tb/fpAddTb.sv
